// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Datapath and register file
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = 5;

    // Fetch and issue widths
    localparam int FETCH_WIDTH = 4;
    localparam int ISSUE_WIDTH = 2;

    // Instruction buffer geometry
    localparam int IB_DEPTH = 16;
    localparam int IB_AW    = $clog2(IB_DEPTH);

    // 3R-type major opcodes, instr[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12 opcode, instr[31:22]
    localparam logic [9:0] OP_ADDI_W = 10'h00a;

    // 1RI20 opcode, instr[31:25]
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_ADDI,
        ALU_LU12I
    } alu_op_e;

    // Slot k sits at pc + 4k
    typedef struct packed {
        logic [XLEN-1:0]                  pc;
        logic [FETCH_WIDTH-1:0][XLEN-1:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } ib_entry_t;

    // Operands already resolved by dispatch
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] rj_val;
        logic [XLEN-1:0] rk_val;
    } lane_in_t;

    // wen is low for r0 and for unknown encodings
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              wen;
        logic [XLEN-1:0]   result;
    } lane_out_t;

endpackage

`default_nettype wire

// File: hw/instr_buffer.sv
`default_nettype none

module instr_buffer import cpu_pkg::*; (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire                              fetch_valid_i,
    input  wire fetch_pkt_t                  fetch_pkt_i,
    output logic                             fetch_ready_o,
    input  wire  [1:0]                       issue_cnt_i,
    output ib_entry_t [ISSUE_WIDTH-1:0]      head_o
);

    logic [XLEN-1:0]  pc_mem    [IB_DEPTH];
    logic [XLEN-1:0]  instr_mem [IB_DEPTH];
    logic [IB_AW-1:0] wr_ptr;
    logic [IB_AW-1:0] rd_ptr;
    logic [IB_AW:0]   count;
    logic             push;

    // Room for a whole packet
    assign fetch_ready_o = (IB_DEPTH - int'(count)) >= FETCH_WIDTH;
    assign push          = fetch_valid_i && fetch_ready_o;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                pc_mem[wr_ptr + IB_AW'(k)]    <= fetch_pkt_i.pc + XLEN'(4 * k);
                instr_mem[wr_ptr + IB_AW'(k)] <= fetch_pkt_i.instr[k];
            end
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + IB_AW'(FETCH_WIDTH);
            end
            rd_ptr <= rd_ptr + IB_AW'(issue_cnt_i);
            count  <= count
                    + (push ? (IB_AW + 1)'(FETCH_WIDTH) : '0)
                    - (IB_AW + 1)'(issue_cnt_i);
        end
    end

    // Oldest entry in slot 0
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            head_o[i].valid = count > (IB_AW + 1)'(i);
            head_o[i].pc    = pc_mem[rd_ptr + IB_AW'(i)];
            head_o[i].instr = instr_mem[rd_ptr + IB_AW'(i)];
        end
    end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`default_nettype none

module regfile import cpu_pkg::*; (
    input  wire                                   clk,
    input  wire                                   rst_n_i,
    input  wire  [ISSUE_WIDTH-1:0]                we_i,
    input  wire  [ISSUE_WIDTH-1:0][REG_AW-1:0]    waddr_i,
    input  wire  [ISSUE_WIDTH-1:0][XLEN-1:0]      wdata_i,
    input  wire  [2*ISSUE_WIDTH-1:0][REG_AW-1:0]  raddr_i,
    output logic [2*ISSUE_WIDTH-1:0][XLEN-1:0]    rdata_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // Later port overrides, port 1 carries the younger instruction
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < ISSUE_WIDTH; p++) begin
                if (we_i[p] && waddr_i[p] != '0) begin
                    regs[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // r0 reads as zero
    always_comb begin
        for (int r = 0; r < 2 * ISSUE_WIDTH; r++) begin
            rdata_o[r] = (raddr_i[r] == '0) ? '0 : regs[raddr_i[r]];
        end
    end

endmodule

`default_nettype wire

// File: hw/dispatch.sv
`default_nettype none

module dispatch import cpu_pkg::*; (
    input  wire                                   clk,
    input  wire                                   rst_n_i,
    input  wire ib_entry_t [ISSUE_WIDTH-1:0]      head_i,
    output logic [1:0]                            issue_cnt_o,
    output logic [2*ISSUE_WIDTH-1:0][REG_AW-1:0]  rf_raddr_o,
    input  wire  [2*ISSUE_WIDTH-1:0][XLEN-1:0]    rf_rdata_i,
    input  wire lane_out_t [ISSUE_WIDTH-1:0]      ex_fwd_i,
    input  wire lane_out_t [ISSUE_WIDTH-1:0]      ex_res_i,
    input  wire lane_out_t [ISSUE_WIDTH-1:0]      wb_res_i,
    output lane_in_t [ISSUE_WIDTH-1:0]            lane_o
);

    lane_out_t [2:0][ISSUE_WIDTH-1:0]   fwd_src;
    logic [2*ISSUE_WIDTH-1:0][XLEN-1:0] opnd;
    logic [REG_AW-1:0]                  older_rd;
    logic                               pair_dep;

    // rj and rk of each head, slot i uses ports 2i and 2i+1
    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            rf_raddr_o[2*i]   = head_i[i].instr[9:5];
            rf_raddr_o[2*i+1] = head_i[i].instr[14:10];
        end
    end

    // Field compare only, so an immediate that aliases a register also splits
    assign older_rd = head_i[0].instr[4:0];
    assign pair_dep = (older_rd != '0)
                   && (older_rd == rf_raddr_o[2] || older_rd == rf_raddr_o[3]);

    always_comb begin
        if (!head_i[0].valid) begin
            issue_cnt_o = 2'd0;
        end else if (head_i[1].valid && !pair_dep) begin
            issue_cnt_o = 2'd2;
        end else begin
            issue_cnt_o = 2'd1;
        end
    end

    // Index 0 is the newest stage
    assign fwd_src[0] = ex_fwd_i;
    assign fwd_src[1] = ex_res_i;
    assign fwd_src[2] = wb_res_i;

    // Oldest source first so that newer matches overwrite it
    always_comb begin
        for (int p = 0; p < 2 * ISSUE_WIDTH; p++) begin
            opnd[p] = rf_rdata_i[p];
            for (int s = 2; s >= 0; s--) begin
                for (int l = 0; l < ISSUE_WIDTH; l++) begin
                    if (fwd_src[s][l].wen && fwd_src[s][l].rd == rf_raddr_o[p]) begin
                        opnd[p] = fwd_src[s][l].result;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lane_o <= '0;
        end else begin
            lane_o[0].valid <= issue_cnt_o != 2'd0;
            lane_o[1].valid <= issue_cnt_o == 2'd2;
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                lane_o[i].pc     <= head_i[i].pc;
                lane_o[i].instr  <= head_i[i].instr;
                lane_o[i].rj_val <= opnd[2*i];
                lane_o[i].rk_val <= opnd[2*i+1];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/ex_lane.sv
`default_nettype none

module ex_lane import cpu_pkg::*; (
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire lane_in_t  lane_i,
    output lane_out_t      fwd_o,
    output lane_out_t      res_o
);

    alu_op_e           op;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   result;
    logic [REG_AW-1:0] rd;

    // Shortest opcode field is checked first
    always_comb begin
        op = ALU_NOP;
        if (lane_i.instr[31:25] == OP_LU12I_W) begin
            op = ALU_LU12I;
        end else if (lane_i.instr[31:22] == OP_ADDI_W) begin
            op = ALU_ADDI;
        end else begin
            case (lane_i.instr[31:15])
                OP_ADD_W: op = ALU_ADD;
                OP_SUB_W: op = ALU_SUB;
                OP_AND:   op = ALU_AND;
                OP_OR:    op = ALU_OR;
                OP_XOR:   op = ALU_XOR;
                default:  op = ALU_NOP;
            endcase
        end
    end

    // si20 into the upper bits, else sign-extended si12
    assign imm = (op == ALU_LU12I) ? {lane_i.instr[24:5], 12'b0}
                                   : {{20{lane_i.instr[21]}}, lane_i.instr[21:10]};

    always_comb begin
        case (op)
            ALU_ADD:   result = lane_i.rj_val + lane_i.rk_val;
            ALU_SUB:   result = lane_i.rj_val - lane_i.rk_val;
            ALU_AND:   result = lane_i.rj_val & lane_i.rk_val;
            ALU_OR:    result = lane_i.rj_val | lane_i.rk_val;
            ALU_XOR:   result = lane_i.rj_val ^ lane_i.rk_val;
            ALU_ADDI:  result = lane_i.rj_val + imm;
            ALU_LU12I: result = imm;
            default:   result = '0;
        endcase
    end

    assign rd = lane_i.instr[4:0];

    always_comb begin
        fwd_o.valid  = lane_i.valid;
        fwd_o.pc     = lane_i.pc;
        fwd_o.rd     = rd;
        fwd_o.wen    = lane_i.valid && (op != ALU_NOP) && (rd != '0);
        fwd_o.result = result;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_o <= '0;
        end else begin
            res_o <= fwd_o;
        end
    end

endmodule

`default_nettype wire

// File: hw/commit.sv
`default_nettype none

module commit import cpu_pkg::*; (
    input  wire                               clk,
    input  wire                               rst_n_i,
    input  wire lane_out_t [ISSUE_WIDTH-1:0]  ex_res_i,
    output lane_out_t [ISSUE_WIDTH-1:0]       wb_res_o,
    output logic                              debug0_wb_valid_o,
    output logic [XLEN-1:0]                   debug0_wb_pc_o,
    output logic                              debug0_wb_rf_wen_o,
    output logic [REG_AW-1:0]                 debug0_wb_rf_wnum_o,
    output logic [XLEN-1:0]                   debug0_wb_rf_wdata_o,
    output logic                              debug1_wb_valid_o,
    output logic [XLEN-1:0]                   debug1_wb_pc_o,
    output logic                              debug1_wb_rf_wen_o,
    output logic [REG_AW-1:0]                 debug1_wb_rf_wnum_o,
    output logic [XLEN-1:0]                   debug1_wb_rf_wdata_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_res_o <= '0;
        end else begin
            wb_res_o <= ex_res_i;
        end
    end

    // Trace channel 0 is always the older instruction
    assign debug0_wb_valid_o    = wb_res_o[0].valid;
    assign debug0_wb_pc_o       = wb_res_o[0].pc;
    assign debug0_wb_rf_wen_o   = wb_res_o[0].wen;
    assign debug0_wb_rf_wnum_o  = wb_res_o[0].rd;
    assign debug0_wb_rf_wdata_o = wb_res_o[0].result;

    assign debug1_wb_valid_o    = wb_res_o[1].valid;
    assign debug1_wb_pc_o       = wb_res_o[1].pc;
    assign debug1_wb_rf_wen_o   = wb_res_o[1].wen;
    assign debug1_wb_rf_wnum_o  = wb_res_o[1].rd;
    assign debug1_wb_rf_wdata_o = wb_res_o[1].result;

endmodule

`default_nettype wire

// File: hw/core_top.sv
`default_nettype none

module core_top import cpu_pkg::*; (
    input  wire               clk,
    input  wire               rst_n_i,
    // Fetch port
    input  wire               fetch_valid_i,
    input  wire fetch_pkt_t   fetch_pkt_i,
    output logic              fetch_ready_o,
    // Commit trace
    output logic              debug0_wb_valid_o,
    output logic [XLEN-1:0]   debug0_wb_pc_o,
    output logic              debug0_wb_rf_wen_o,
    output logic [REG_AW-1:0] debug0_wb_rf_wnum_o,
    output logic [XLEN-1:0]   debug0_wb_rf_wdata_o,
    output logic              debug1_wb_valid_o,
    output logic [XLEN-1:0]   debug1_wb_pc_o,
    output logic              debug1_wb_rf_wen_o,
    output logic [REG_AW-1:0] debug1_wb_rf_wnum_o,
    output logic [XLEN-1:0]   debug1_wb_rf_wdata_o
);

    ib_entry_t [ISSUE_WIDTH-1:0]         head;
    logic [1:0]                          issue_cnt;
    logic [2*ISSUE_WIDTH-1:0][REG_AW-1:0] rf_raddr;
    logic [2*ISSUE_WIDTH-1:0][XLEN-1:0]   rf_rdata;
    lane_in_t  [ISSUE_WIDTH-1:0]         lane_in;
    lane_out_t [ISSUE_WIDTH-1:0]         ex_fwd;
    lane_out_t [ISSUE_WIDTH-1:0]         ex_res;
    lane_out_t [ISSUE_WIDTH-1:0]         wb_res;

    instr_buffer u_instr_buffer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pkt_i   (fetch_pkt_i),
        .fetch_ready_o (fetch_ready_o),
        .issue_cnt_i   (issue_cnt),
        .head_o        (head)
    );

    dispatch u_dispatch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .head_i      (head),
        .issue_cnt_o (issue_cnt),
        .rf_raddr_o  (rf_raddr),
        .rf_rdata_i  (rf_rdata),
        .ex_fwd_i    (ex_fwd),
        .ex_res_i    (ex_res),
        .wb_res_i    (wb_res),
        .lane_o      (lane_in)
    );

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : lane
        ex_lane u_ex_lane (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .lane_i  (lane_in[i]),
            .fwd_o   (ex_fwd[i]),
            .res_o   (ex_res[i])
        );
    end

    commit u_commit (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .ex_res_i             (ex_res),
        .wb_res_o             (wb_res),
        .debug0_wb_valid_o    (debug0_wb_valid_o),
        .debug0_wb_pc_o       (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o   (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o  (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o (debug0_wb_rf_wdata_o),
        .debug1_wb_valid_o    (debug1_wb_valid_o),
        .debug1_wb_pc_o       (debug1_wb_pc_o),
        .debug1_wb_rf_wen_o   (debug1_wb_rf_wen_o),
        .debug1_wb_rf_wnum_o  (debug1_wb_rf_wnum_o),
        .debug1_wb_rf_wdata_o (debug1_wb_rf_wdata_o)
    );

    // Write ports straight from the commit register
    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    ({wb_res[1].wen, wb_res[0].wen}),
        .waddr_i ({wb_res[1].rd, wb_res[0].rd}),
        .wdata_i ({wb_res[1].result, wb_res[0].result}),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata)
    );

endmodule

`default_nettype wire

// File: tests/core_properties.sv
`default_nettype none

module core_properties import cpu_pkg::*; (
    input wire              clk,
    input wire              rst_n_i,
    input wire              fetch_valid_i,
    input wire fetch_pkt_t  fetch_pkt_i,
    input wire              fetch_ready_o,
    input wire              debug0_wb_valid_o,
    input wire [XLEN-1:0]   debug0_wb_pc_o,
    input wire              debug0_wb_rf_wen_o,
    input wire [REG_AW-1:0] debug0_wb_rf_wnum_o,
    input wire              debug1_wb_valid_o,
    input wire [XLEN-1:0]   debug1_wb_pc_o,
    input wire              debug1_wb_rf_wen_o,
    input wire [REG_AW-1:0] debug1_wb_rf_wnum_o
);

    int violations = 0;

    // Stalled packet is held until the transfer
    fetch_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_valid_i && !fetch_ready_o |=> fetch_valid_i && $stable(fetch_pkt_i))
        else begin
            $error("fetch packet changed while stalled");
            violations++;
        end

    trace_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        debug1_wb_valid_o |-> debug0_wb_valid_o)
        else begin
            $error("channel 1 valid without channel 0");
            violations++;
        end

    // Channel 1 is the next instruction in program order
    trace_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        debug0_wb_valid_o && debug1_wb_valid_o |-> debug1_wb_pc_o == debug0_wb_pc_o + 32'd4)
        else begin
            $error("channel 1 pc does not follow channel 0");
            violations++;
        end

    wen0_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        debug0_wb_rf_wen_o |-> debug0_wb_valid_o && debug0_wb_rf_wnum_o != '0)
        else begin
            $error("channel 0 write enable on invalid slot or r0");
            violations++;
        end

    wen1_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        debug1_wb_rf_wen_o |-> debug1_wb_valid_o && debug1_wb_rf_wnum_o != '0)
        else begin
            $error("channel 1 write enable on invalid slot or r0");
            violations++;
        end

    reset_quiet: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !debug0_wb_valid_o && !debug1_wb_valid_o)
        else begin
            $error("commit reported right after reset release");
            violations++;
        end

endmodule

bind core_top core_properties u_props (.*);

`default_nettype wire

// File: tests/tb_core.sv
`default_nettype none

module tb_core import cpu_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    // Instructions over all six tests
    localparam int N_TOTAL    = 16 + 16 + 8 + 64 + 200;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic              wen;
        logic [REG_AW-1:0] wnum;
        logic [XLEN-1:0]   wdata;
    } commit_rec_t;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              fetch_valid_i;
    fetch_pkt_t        fetch_pkt_i;
    logic              fetch_ready_o;
    logic              debug0_wb_valid_o;
    logic [XLEN-1:0]   debug0_wb_pc_o;
    logic              debug0_wb_rf_wen_o;
    logic [REG_AW-1:0] debug0_wb_rf_wnum_o;
    logic [XLEN-1:0]   debug0_wb_rf_wdata_o;
    logic              debug1_wb_valid_o;
    logic [XLEN-1:0]   debug1_wb_pc_o;
    logic              debug1_wb_rf_wen_o;
    logic [REG_AW-1:0] debug1_wb_rf_wnum_o;
    logic [XLEN-1:0]   debug1_wb_rf_wdata_o;

    logic [XLEN-1:0] model_regs [NUM_REGS];
    commit_rec_t     exp_q [$];
    logic [XLEN-1:0] prog_q [$];
    logic [XLEN-1:0] model_pc;
    logic [XLEN-1:0] send_pc;
    integer          seed;
    int              error_cnt;
    int              pass_cnt;
    int              fail_cnt;
    int              mark;
    logic            saw_full;

    core_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int total_errors();
        return error_cnt + dut0.u_props.violations;
    endfunction

    // ALU_NOP builds an encoding that matches no opcode
    function automatic logic [XLEN-1:0] make_instr(input alu_op_e op, input logic [4:0] rd,
                                                   input logic [4:0] rj, input logic [4:0] rk,
                                                   input logic [19:0] imm);
        case (op)
            ALU_ADD:   return {OP_ADD_W, rk, rj, rd};
            ALU_SUB:   return {OP_SUB_W, rk, rj, rd};
            ALU_AND:   return {OP_AND, rk, rj, rd};
            ALU_OR:    return {OP_OR, rk, rj, rd};
            ALU_XOR:   return {OP_XOR, rk, rj, rd};
            ALU_ADDI:  return {OP_ADDI_W, imm[11:0], rj, rd};
            ALU_LU12I: return {OP_LU12I_W, imm, rd};
            default:   return {12'hfff, imm};
        endcase
    endfunction

    // Reference model, one instruction in program order
    function automatic void add_instr(input logic [XLEN-1:0] w);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            known;
        commit_rec_t     rec;
        a     = model_regs[w[9:5]];
        b     = model_regs[w[14:10]];
        known = 1'b1;
        if (w[31:25] == OP_LU12I_W) res = {w[24:5], 12'h000};
        else if (w[31:22] == OP_ADDI_W) res = a + {{20{w[21]}}, w[21:10]};
        else if (w[31:15] == OP_ADD_W) res = a + b;
        else if (w[31:15] == OP_SUB_W) res = a - b;
        else if (w[31:15] == OP_AND) res = a & b;
        else if (w[31:15] == OP_OR) res = a | b;
        else if (w[31:15] == OP_XOR) res = a ^ b;
        else known = 1'b0;
        rec.pc    = model_pc;
        rec.wnum  = w[4:0];
        rec.wen   = known && (w[4:0] != '0);
        rec.wdata = res;
        if (rec.wen) model_regs[w[4:0]] = res;
        exp_q.push_back(rec);
        prog_q.push_back(w);
        model_pc = model_pc + 32'd4;
    endfunction

    task automatic report_error(input string what, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        error_cnt++;
    endtask

    task automatic check_commit(input int ch, input logic [XLEN-1:0] pc, input logic wen,
                                input logic [REG_AW-1:0] wnum, input logic [XLEN-1:0] wdata);
        commit_rec_t exp;
        assert (exp_q.size() > 0) else begin
            $display("** Error at %0t: debug%0d reported a commit nobody issued", $time, ch);
            error_cnt++;
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            assert (pc == exp.pc) else report_error($sformatf("debug%0d_wb_pc", ch), pc, exp.pc);
            assert (wen == exp.wen)
                else report_error($sformatf("debug%0d_wb_rf_wen", ch), wen, exp.wen);
            assert (wnum == exp.wnum)
                else report_error($sformatf("debug%0d_wb_rf_wnum", ch), wnum, exp.wnum);
            // Data only matters when the register is written
            assert (!exp.wen || wdata == exp.wdata)
                else report_error($sformatf("debug%0d_wb_rf_wdata", ch), wdata, exp.wdata);
        end
    endtask

    // Channel 0 holds the older instruction
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (debug0_wb_valid_o) begin
                check_commit(0, debug0_wb_pc_o, debug0_wb_rf_wen_o, debug0_wb_rf_wnum_o,
                             debug0_wb_rf_wdata_o);
            end
            if (debug1_wb_valid_o) begin
                check_commit(1, debug1_wb_pc_o, debug1_wb_rf_wen_o, debug1_wb_rf_wnum_o,
                             debug1_wb_rf_wdata_o);
            end
        end
    end

    task automatic send_program(input int max_gap);
        fetch_pkt_t      pkt;
        logic [XLEN-1:0] r;
        saw_full = 1'b0;
        while (prog_q.size() >= FETCH_WIDTH) begin
            pkt.pc = send_pc;
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                pkt.instr[k] = prog_q.pop_front();
            end
            send_pc = send_pc + 32'(4 * FETCH_WIDTH);
            if (max_gap > 0) begin
                r = $random(seed);
                repeat (r % (max_gap + 1)) @(negedge clk);
            end
            fetch_valid_i = 1'b1;
            fetch_pkt_i   = pkt;
            while (!fetch_ready_o) begin
                saw_full = 1'b1;
                @(negedge clk);
            end
            @(negedge clk);
            fetch_valid_i = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int max_gap, input bit check_full);
        send_program(max_gap);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        if (check_full) begin
            assert (saw_full) else begin
                $display("** Error at %0t: fetch_ready_o never dropped in the stream", $time);
                error_cnt++;
            end
        end
        if (total_errors() == mark) begin
            pass_cnt++;
            $display("Test %s passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s failed with %0d errors", name, total_errors() - mark);
        end
        mark = total_errors();
    endtask

    initial begin
        logic [XLEN-1:0] r;
        seed          = 32'hb4ba;
        error_cnt     = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        mark          = 0;
        saw_full      = 1'b0;
        model_pc      = 32'h1c00_0000;
        send_pc       = 32'h1c00_0000;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pkt_i   = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;

        repeat (4) begin
            @(negedge clk);
            assert (fetch_ready_o) else report_error("fetch_ready_o", 0, 1);
            assert (!debug0_wb_valid_o && !debug1_wb_valid_o)
                else report_error("debug valid", 1, 0);
        end
        run_test("reset", 0, 0);

        for (int i = 0; i < 16; i++) begin
            add_instr(make_instr(alu_op_e'(7 - i % 7), 5'(1 + i), 5'(1 + i % 3), 5'(2 + i % 2),
                                 20'(i * 4951 + 9320)));
        end
        run_test("basic alu ops", 3, 0);

        // Odd steps read i-1, even steps i-2, rk is always i-3
        for (int i = 0; i < 16; i++) begin
            add_instr(make_instr(alu_op_e'(1 + i % 6), 5'(1 + i % 8),
                                 5'(1 + (i + 6 + i % 2) % 8), 5'(1 + (i + 5) % 8),
                                 20'(3 * i + 1)));
        end
        run_test("dependency chains", 3, 0);

        add_instr(make_instr(ALU_NOP, 5'd0, 5'd0, 5'd0, 20'h00ca3));
        add_instr(make_instr(ALU_ADDI, 5'd0, 5'd1, 5'd0, 20'h00123));
        add_instr(make_instr(ALU_ADD, 5'd0, 5'd2, 5'd3, 20'h0));
        add_instr(make_instr(ALU_ADD, 5'd9, 5'd0, 5'd0, 20'h0));
        add_instr(make_instr(ALU_LU12I, 5'd0, 5'd0, 5'd0, 20'h12345));
        add_instr(make_instr(ALU_ADDI, 5'd10, 5'd0, 5'd0, 20'h00fff));
        add_instr(make_instr(ALU_NOP, 5'd0, 5'd0, 5'd0, 20'h3fd2a));
        add_instr(make_instr(ALU_OR, 5'd11, 5'd0, 5'd10, 20'h0));
        run_test("unknown and r0", 3, 0);

        for (int i = 0; i < 64; i++) begin
            add_instr(make_instr(alu_op_e'(1 + i % 7), 5'(1 + i % 31), 5'((i * 7) % 32),
                                 5'((i * 11) % 32), 20'(i * 40503)));
        end
        run_test("back-to-back stream", 0, 1);

        // Op code 0 gives an unknown encoding
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            add_instr(make_instr(alu_op_e'(r[2:0]), r[7:3], r[12:8], r[17:13], r[31:12]));
        end
        run_test("random program", 3, 0);

        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && total_errors() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * 40 * (N_TOTAL + 100));
        $display("Run timed out waiting for commits");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hw/cpu_pkg.sv
hw/instr_buffer.sv
hw/regfile.sv
hw/dispatch.sv
hw/ex_lane.sv
hw/commit.sv
hw/core_top.sv
tests/core_properties.sv
tests/tb_core.sv
